// ==== source/mma_pkg.sv ====
package mma_pkg;

    // accumulate mode carried with every operand set
    typedef enum logic [1:0] {
        OP_MAC  = 2'd0, // a*b + c
        OP_MUL  = 2'd1, // a*b, c ignored
        OP_NMAC = 2'd2, // c - a*b
        OP_RSVD = 2'd3
    } mma_op_e;

    // default matrix shape, A is M x K and B is K x N
    localparam int DEF_M = 2;
    localparam int DEF_N = 2;
    localparam int DEF_K = 2;
    localparam int DEF_P = 8;  // element width, accumulators are 4x this

    localparam int DEF_STAGES = 2;
    localparam int DEF_TREE   = 1;  // 1 adder tree, 0 adder chain

endpackage

// ==== source/mma_stage_if.sv ====
`timescale 1ns/1ps

interface mma_stage_if #(
    parameter int M,
    parameter int N,
    parameter int K,
    parameter int P
)(
    input logic clk_i
);
    logic                  valid;
    logic                  ready;
    logic signed [P-1:0]   a [M][K];
    logic signed [P-1:0]   b [K][N];
    logic signed [4*P-1:0] c [M][N];
    logic                  acc_en; // c takes part in the result
    logic                  sub;    // c minus product sum

    modport src (
        input  clk_i,
        input  ready,
        output valid,
        output a,
        output b,
        output c,
        output acc_en,
        output sub
    );

    modport dst (
        input  clk_i,
        input  valid,
        input  a,
        input  b,
        input  c,
        input  acc_en,
        input  sub,
        output ready
    );

endinterface

// ==== source/mma_ingress.sv ====
`timescale 1ns/1ps

module mma_ingress import mma_pkg::*; #(
    parameter int M,
    parameter int N,
    parameter int K,
    parameter int P
)(
    input  logic [M*K*P-1:0]   a_flat,
    input  logic [K*N*P-1:0]   b_flat,
    input  logic [M*N*4*P-1:0] c_flat,
    input  mma_op_e            op,
    input  logic               valid_in,
    output logic               ready_in,
    mma_stage_if.src           out
);
    localparam int ACC_W = 4 * P;

    // row-major, element [0][0] in the low bits
    always_comb begin
        for (int i = 0; i < M; i++) begin
            for (int k = 0; k < K; k++) begin
                out.a[i][k] = a_flat[(i*K+k)*P +: P];
            end
        end
        for (int k = 0; k < K; k++) begin
            for (int j = 0; j < N; j++) begin
                out.b[k][j] = b_flat[(k*N+j)*P +: P];
            end
        end
        for (int i = 0; i < M; i++) begin
            for (int j = 0; j < N; j++) begin
                out.c[i][j] = c_flat[(i*N+j)*ACC_W +: ACC_W];
            end
        end
    end

    always_comb begin
        case (op)
            OP_MAC: begin
                out.acc_en = 1'b1;
                out.sub    = 1'b0;
            end
            OP_NMAC: begin
                out.acc_en = 1'b1;
                out.sub    = 1'b1;
            end
            default: begin // MUL, reserved never accepted
                out.acc_en = 1'b0;
                out.sub    = 1'b0;
            end
        endcase
    end

    assign out.valid = valid_in;
    assign ready_in  = out.ready;

    // opcode 3 is reserved
    assert property (@(posedge out.clk_i) valid_in |-> op != OP_RSVD)
        else $error("mma_ingress: reserved opcode offered with valid_in");

    // an offered set is held until the buffer takes it
    assert property (@(posedge out.clk_i)
        valid_in && !ready_in |=> valid_in && $stable(a_flat) && $stable(b_flat)
            && $stable(c_flat) && $stable(op))
        else $error("mma_ingress: input changed while stalled");

endmodule

// ==== source/mma_pipe_buffer.sv ====
`timescale 1ns/1ps

module mma_pipe_buffer #(
    parameter int M,
    parameter int N,
    parameter int K,
    parameter int P,
    parameter int STAGES
)(
    input  logic     clk_i,
    input  logic     arst_n,
    mma_stage_if.dst in,
    mma_stage_if.src out
);
    localparam int ACC_W = 4 * P;
    localparam int OFF_B = M * K * P;
    localparam int OFF_C = OFF_B + K * N * P;
    localparam int OFF_F = OFF_C + M * N * ACC_W; // mode flags
    localparam int PAY_W = OFF_F + 2;

    logic [PAY_W-1:0] in_bits;
    logic [PAY_W-1:0] out_bits;

    always_comb begin
        for (int i = 0; i < M; i++) begin
            for (int k = 0; k < K; k++) begin
                in_bits[(i*K+k)*P +: P] = in.a[i][k];
            end
        end
        for (int k = 0; k < K; k++) begin
            for (int j = 0; j < N; j++) begin
                in_bits[OFF_B+(k*N+j)*P +: P] = in.b[k][j];
            end
        end
        for (int i = 0; i < M; i++) begin
            for (int j = 0; j < N; j++) begin
                in_bits[OFF_C+(i*N+j)*ACC_W +: ACC_W] = in.c[i][j];
            end
        end
        in_bits[OFF_F]   = in.acc_en;
        in_bits[OFF_F+1] = in.sub;
    end

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        logic             valid_q;
        logic [PAY_W-1:0] pay_q;
        logic             up_valid;
        logic [PAY_W-1:0] up_pay;
        logic             down_ready;
        logic             load;

        if (s == 0) begin : g_head
            assign up_valid = in.valid;
            assign up_pay   = in_bits;
        end else begin : g_link
            assign up_valid = g_stage[s-1].valid_q;
            assign up_pay   = g_stage[s-1].pay_q;
        end

        if (s == STAGES - 1) begin : g_tail
            assign down_ready = out.ready;
        end else begin : g_mid
            assign down_ready = g_stage[s+1].load;
        end

        assign load = !valid_q || down_ready; // empty or draining

        always_ff @(posedge clk_i or negedge arst_n) begin
            if (!arst_n) begin
                valid_q <= 1'b0;
            end else if (load) begin
                valid_q <= up_valid;
            end
        end

        always_ff @(posedge clk_i) begin
            if (load && up_valid) begin
                pay_q <= up_pay;
            end
        end
    end

    assign in.ready  = g_stage[0].load;
    assign out.valid = g_stage[STAGES-1].valid_q;
    assign out_bits  = g_stage[STAGES-1].pay_q;

    always_comb begin
        for (int i = 0; i < M; i++) begin
            for (int k = 0; k < K; k++) begin
                out.a[i][k] = out_bits[(i*K+k)*P +: P];
            end
        end
        for (int k = 0; k < K; k++) begin
            for (int j = 0; j < N; j++) begin
                out.b[k][j] = out_bits[OFF_B+(k*N+j)*P +: P];
            end
        end
        for (int i = 0; i < M; i++) begin
            for (int j = 0; j < N; j++) begin
                out.c[i][j] = out_bits[OFF_C+(i*N+j)*ACC_W +: ACC_W];
            end
        end
        out.acc_en = out_bits[OFF_F];
        out.sub    = out_bits[OFF_F+1];
    end

    // a stalled result stays put
    assert property (@(posedge clk_i) disable iff (!arst_n)
        out.valid && !out.ready |=> out.valid && $stable(out_bits))
        else $error("mma_pipe_buffer: output changed under back-pressure");

endmodule

// ==== source/binary_tree_adder.sv ====
`timescale 1ns/1ps

module binary_tree_adder #(
    parameter int INPUTS,
    parameter int P
)(
    input  logic signed [4*P-1:0] terms [INPUTS],
    output logic signed [4*P-1:0] sum
);
    localparam int ACC_W = 4 * P;

    if (INPUTS == 1) begin : g_leaf
        assign sum = terms[0];
    end else if (INPUTS == 2) begin : g_pair
        assign sum = terms[0] + terms[1];
    end else begin : g_split
        // halves differ by at most one, depth stays ceil(log2)
        localparam int LO = INPUTS / 2;
        localparam int HI = INPUTS - LO;

        logic signed [ACC_W-1:0] lo_terms [LO];
        logic signed [ACC_W-1:0] hi_terms [HI];
        logic signed [ACC_W-1:0] lo_sum;
        logic signed [ACC_W-1:0] hi_sum;

        for (genvar t = 0; t < LO; t++) begin : g_lo
            assign lo_terms[t] = terms[t];
        end
        for (genvar t = 0; t < HI; t++) begin : g_hi
            assign hi_terms[t] = terms[LO+t];
        end

        binary_tree_adder #(
            .INPUTS (LO),
            .P      (P)
        ) u_lo (
            .terms (lo_terms),
            .sum   (lo_sum)
        );

        binary_tree_adder #(
            .INPUTS (HI),
            .P      (P)
        ) u_hi (
            .terms (hi_terms),
            .sum   (hi_sum)
        );

        assign sum = lo_sum + hi_sum; // wraps at 4P bits
    end

endmodule

// ==== source/mma_compute.sv ====
`timescale 1ns/1ps

module mma_compute #(
    parameter int M,
    parameter int N,
    parameter int K,
    parameter int P,
    parameter int TREE
)(
    mma_stage_if.dst           in,
    output logic [M*N*4*P-1:0] d_flat,
    output logic               valid_out,
    input  logic               ready_out
);
    localparam int ACC_W = 4 * P;

    for (genvar i = 0; i < M; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            logic signed [ACC_W-1:0] prod [K];
            logic signed [ACC_W-1:0] dot;
            logic signed [ACC_W-1:0] res;

            // both factors sign-extended before the multiply
            for (genvar k = 0; k < K; k++) begin : g_prod
                assign prod[k] = ACC_W'(in.a[i][k]) * ACC_W'(in.b[k][j]);
            end

            if (TREE != 0) begin : g_tree
                binary_tree_adder #(
                    .INPUTS (K),
                    .P      (P)
                ) u_tree (
                    .terms (prod),
                    .sum   (dot)
                );
            end else begin : g_chain
                logic signed [ACC_W-1:0] part [K+1];

                assign part[0] = '0;
                for (genvar k = 0; k < K; k++) begin : g_link
                    assign part[k+1] = part[k] + prod[k];
                end
                assign dot = part[K];
            end

            always_comb begin
                if (!in.acc_en) begin
                    res = dot;                 // MUL
                end else if (in.sub) begin
                    res = in.c[i][j] - dot;    // NMAC
                end else begin
                    res = in.c[i][j] + dot;
                end
            end

            assign d_flat[(i*N+j)*ACC_W +: ACC_W] = res;
        end
    end

    // no state here, handshake passes straight through
    assign valid_out = in.valid;
    assign in.ready  = ready_out;

endmodule

// ==== source/mma_top.sv ====
`timescale 1ns/1ps

module mma_top import mma_pkg::*; #(
    parameter int M      = DEF_M,
    parameter int N      = DEF_N,
    parameter int K      = DEF_K,
    parameter int P      = DEF_P,
    parameter int STAGES = DEF_STAGES,
    parameter int TREE   = DEF_TREE
)(
    input  logic               clk_i,
    input  logic               arst_n,
    input  logic [M*K*P-1:0]   a_flat,
    input  logic [K*N*P-1:0]   b_flat,
    input  logic [M*N*4*P-1:0] c_flat,
    input  mma_op_e            op,
    input  logic               valid_in,
    output logic               ready_in,
    output logic [M*N*4*P-1:0] d_flat,
    output logic               valid_out,
    input  logic               ready_out
);

    mma_stage_if #(
        .M (M),
        .N (N),
        .K (K),
        .P (P)
    ) ingress_to_buf (
        .clk_i (clk_i)
    );

    mma_stage_if #(
        .M (M),
        .N (N),
        .K (K),
        .P (P)
    ) buf_to_compute (
        .clk_i (clk_i)
    );

    mma_ingress #(
        .M (M),
        .N (N),
        .K (K),
        .P (P)
    ) u_ingress (
        .a_flat   (a_flat),
        .b_flat   (b_flat),
        .c_flat   (c_flat),
        .op       (op),
        .valid_in (valid_in),
        .ready_in (ready_in),
        .out      (ingress_to_buf.src)
    );

    mma_pipe_buffer #(
        .M      (M),
        .N      (N),
        .K      (K),
        .P      (P),
        .STAGES (STAGES)
    ) u_buffer (
        .clk_i  (clk_i),
        .arst_n (arst_n),
        .in     (ingress_to_buf.dst),
        .out    (buf_to_compute.src)
    );

    mma_compute #(
        .M    (M),
        .N    (N),
        .K    (K),
        .P    (P),
        .TREE (TREE)
    ) u_compute (
        .in        (buf_to_compute.dst),
        .d_flat    (d_flat),
        .valid_out (valid_out),
        .ready_out (ready_out)
    );

endmodule

// ==== sim/mma_checker.sv ====
`timescale 1ns/1ps

module mma_checker import mma_pkg::*; #(
    parameter int M,
    parameter int N,
    parameter int K,
    parameter int P,
    parameter int STAGES
)(
    input  logic               clk_i,
    input  logic               arst_n,
    input  logic [M*K*P-1:0]   a_flat,
    input  logic [K*N*P-1:0]   b_flat,
    input  logic [M*N*4*P-1:0] c_flat,
    input  mma_op_e            op,
    input  logic               valid_in,
    input  logic               ready_in,
    input  logic [M*N*4*P-1:0] d_flat,
    input  logic               valid_out,
    input  logic               ready_out,
    input  int                 test_id,
    output int                 errors,
    output int                 checked,
    output int                 pending
);
    localparam int ACC_W = 4 * P;
    localparam int D_W   = M * N * ACC_W;

    logic [D_W-1:0] expect_q [$];
    int             accept_q [$]; // cycle each set went in
    int             cycle   = 0;
    int             err_cnt = 0;
    int             chk_cnt = 0;

    function automatic string name_of(input int id);
        case (id)
            1:       return "mac";
            2:       return "mul";
            3:       return "nmac";
            4:       return "backpressure";
            default: return "reset";
        endcase
    endfunction

    // wide sums cut back to ACC_W so they wrap
    function automatic logic [D_W-1:0] expected_d(input logic [M*K*P-1:0] a,
        input logic [K*N*P-1:0] b, input logic [D_W-1:0] c, input mma_op_e o);
        logic [D_W-1:0] d;
        longint         dot;
        longint         acc;
        d = '0;
        for (int i = 0; i < M; i++) begin
            for (int j = 0; j < N; j++) begin
                dot = 0;
                for (int k = 0; k < K; k++) begin
                    dot += longint'($signed(a[(i*K+k)*P +: P]))
                        * longint'($signed(b[(k*N+j)*P +: P]));
                end
                acc = longint'($signed(c[(i*N+j)*ACC_W +: ACC_W]));
                case (o)
                    OP_MUL:  acc = dot;
                    OP_NMAC: acc = acc - dot;
                    default: acc = acc + dot;
                endcase
                d[(i*N+j)*ACC_W +: ACC_W] = acc[ACC_W-1:0];
            end
        end
        return d;
    endfunction

    always @(posedge clk_i) begin : watch
        logic [D_W-1:0] exp_d;
        int             t0;
        int             idx;
        cycle++;
        if (arst_n && valid_out && ready_out) begin
            if (expect_q.size() == 0) begin
                $display("a result came out with no input set outstanding in the %s test",
                    name_of(test_id));
                err_cnt++;
            end else begin
                exp_d = expect_q.pop_front();
                t0    = accept_q.pop_front();
                chk_cnt++;
                for (int i = 0; i < M; i++) begin
                    for (int j = 0; j < N; j++) begin
                        idx = (i * N + j) * ACC_W;
                        if (d_flat[idx +: ACC_W] !== exp_d[idx +: ACC_W]) begin
                            $display("error %s d[%0d][%0d]: expected %0d, actual %0d",
                                name_of(test_id), i, j, $signed(exp_d[idx +: ACC_W]),
                                $signed(d_flat[idx +: ACC_W]));
                            err_cnt++;
                        end
                    end
                end
                // mac test streams with valid_in and ready_out high
                if (test_id == 1 && cycle - t0 != STAGES) begin
                    $display("error %s latency: expected %0d, actual %0d",
                        name_of(test_id), STAGES, cycle - t0);
                    err_cnt++;
                end
            end
        end
        if (arst_n && valid_in && ready_in) begin
            expect_q.push_back(expected_d(a_flat, b_flat, c_flat, op));
            accept_q.push_back(cycle);
        end
        errors  <= err_cnt;
        checked <= chk_cnt;
        pending <= expect_q.size();
    end

endmodule

// ==== sim/mma_tb.sv ====
`timescale 1ns/1ps

module mma_tb import mma_pkg::*;;
    localparam int M     = DEF_M;
    localparam int N     = DEF_N;
    localparam int K     = DEF_K;
    localparam int P     = DEF_P;
    localparam int ACC_W = 4 * P;
    localparam int TOTAL = 3 * 64 + 128;
    localparam int LIMIT = TOTAL * (DEF_STAGES + 8) + 200;

    logic               clk_i = 1'b0;
    logic               arst_n;
    logic [M*K*P-1:0]   a_flat;
    logic [K*N*P-1:0]   b_flat;
    logic [M*N*ACC_W-1:0] c_flat;
    mma_op_e            op;
    logic               valid_in;
    logic               ready_in;
    logic [M*N*ACC_W-1:0] d_flat;
    logic               valid_out;
    logic               ready_out;
    int                 test_id = 0;
    int                 errors;
    int                 checked;
    int                 pending;
    int                 tb_errors = 0;
    int                 cycles = 0;
    logic [31:0]        lfsr = 32'h9c56;

    always #4 clk_i = ~clk_i;

    mma_top dut (.*);

    mma_checker #(
        .M (M), .N (N), .K (K), .P (P),
        .STAGES (DEF_STAGES)
    ) chk (.*);

    // galois form, one step per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [P-1:0] element(input logic extreme);
        logic [1:0] pick;
        pick = extreme ? 2'(take_bits(2)) : 2'd3;
        case (pick)
            2'd0:    return {1'b1, {(P-1){1'b0}}}; // most negative
            2'd1:    return {1'b0, {(P-1){1'b1}}};
            default: return P'(take_bits(P));
        endcase
    endfunction

    function automatic logic [ACC_W-1:0] acc_value(input logic extreme);
        logic [1:0] pick;
        pick = extreme ? 2'(take_bits(2)) : 2'd3;
        case (pick)
            2'd0:    return {1'b1, {(ACC_W-1){1'b0}}};
            2'd1:    return {1'b0, {(ACC_W-1){1'b1}}};
            default: return ACC_W'(take_bits(ACC_W));
        endcase
    endfunction

    task automatic load_set(input int id);
        logic [M*K*P-1:0]     a;
        logic [K*N*P-1:0]     b;
        logic [M*N*ACC_W-1:0] c;
        mma_op_e              o;
        for (int e = 0; e < M * K; e++) begin
            a[e*P +: P] = element(id == 3);
        end
        for (int e = 0; e < K * N; e++) begin
            b[e*P +: P] = element(id == 3);
        end
        for (int e = 0; e < M * N; e++) begin
            c[e*ACC_W +: ACC_W] = acc_value(id == 3); // extreme c makes c - a*b wrap
        end
        case (id)
            1:       o = OP_MAC;
            2:       o = OP_MUL;
            3:       o = OP_NMAC;
            default: o = mma_op_e'(2'(take_bits(2)));
        endcase
        if (o == OP_RSVD) begin
            o = OP_MAC;
        end
        a_flat <= a;
        b_flat <= b;
        c_flat <= c;
        op     <= o;
    endtask

    // valid_in and ready_out are random only in test 4
    task automatic run_sets(input string name, input int id, input int n);
        int accepted;
        int offered;
        int err0;
        accepted = 0;
        offered  = 0;
        err0     = errors;
        test_id <= id;
        while (accepted < n) begin
            @(posedge clk_i);
            if (valid_in && ready_in) begin
                accepted++;
            end
            if (!valid_in || ready_in) begin
                if (offered < n && (id != 4 || 1'(take_bits(1)))) begin
                    load_set(id);
                    valid_in <= 1'b1;
                    offered++;
                end else begin
                    valid_in <= 1'b0;
                end
            end
            ready_out <= (id == 4) ? 1'(take_bits(1)) : 1'b1;
        end
        ready_out <= 1'b1;
        do begin
            @(posedge clk_i);
        end while (pending != 0);
        $display("test %s done: %0d sets, %0d errors", name, n, errors - err0);
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic bad;
        arst_n    = 1'b0;
        a_flat    = '0;
        b_flat    = '0;
        c_flat    = '0;
        op        = OP_MAC;
        valid_in  = 1'b0;
        ready_out = 1'b1;
        repeat (4) @(posedge clk_i);
        arst_n <= 1'b1;
        @(posedge clk_i);
        bad = valid_out !== 1'b0 || ready_in !== 1'b1;
        if (bad) begin
            $display("after reset valid_out is not low or ready_in is not high");
            tb_errors++;
        end
        $display("test reset done: %s", bad ? "1 error" : "0 errors");
        run_sets("mac", 1, 64);
        run_sets("mul", 2, 64);
        run_sets("nmac", 3, 64);
        run_sets("backpressure", 4, 128);
        if (pending != 0) begin
            $display("%0d accepted sets never produced a result", pending);
            tb_errors++;
        end
        if (checked != TOTAL) begin
            $display("got %0d results for %0d accepted sets", checked, TOTAL);
            tb_errors++;
        end
        $display("5 tests, %0d results checked, %0d compare errors, %0d other errors",
            checked, errors, tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
source/mma_pkg.sv
source/mma_stage_if.sv
source/mma_ingress.sv
source/mma_pipe_buffer.sv
source/binary_tree_adder.sv
source/mma_compute.sv
source/mma_top.sv
sim/mma_checker.sv
sim/mma_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mma_tb
BUILD_DIR ?= build

SOURCES := $(shell grep -v '^+' all.f)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): all.f $(SOURCES)
	$(VERILATOR) --binary --timing --top-module $(TOP) -f all.f -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
